// ==== Makefile ====
# Verilator simulation of the VMA board

VERILATOR ?= verilator
TOP       ?= vmaTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
SIM_ARGS  ?=

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim.f ====
+incdir+include
source/vmaPkg.sv
source/vmaAddressPath.sv
source/vmaContextRegs.sv
source/vmaStatus.sv
source/vmaTop.sv
sim/vmaTb.sv

// ==== include/vmaTbModel.svh ====
`ifndef VMA_TB_MODEL_SVH
`define VMA_TB_MODEL_SVH

// In-section address the adder should form
function automatic logic [0:17] modelAdder(
  input logic [13:35] pc,
  input logic [0:3]   trapMix,
  input logic         pcInc,
  input logic         condVmaMagic,
  input logic [0:8]   magic
);
  logic [0:17] sum;
  if (condVmaMagic) begin
    sum = {9'b0, magic};
  end else begin
    sum = pc[18:35] + {14'b0, trapMix} + {17'b0, pcInc};
  end
  return sum;
endfunction

// Next VMA after one clock with load ahead of count
function automatic logic [13:35] modelNextVma(
  input logic [13:35]     vma,
  input logic [13:35]     pc,
  input logic [0:4]       prevSec,
  input logic [0:35]      adData,
  input logic [0:17]      adderOut,
  input logic             loadVma,
  input logic             incVma,
  input logic             vmaFromAdder,
  input vmaPkg::secSrcT   secSrc
);
  logic [0:4] sec;
  logic [13:35] next;
  case (secSrc)
    vmaPkg::pcSec:   sec = pc[13:17];
    vmaPkg::prevSec: sec = prevSec;
    vmaPkg::adSec:   sec = adData[13:17];
    default:         sec = vma[13:17];
  endcase
  if (loadVma) begin
    next = {sec, vmaFromAdder ? adderOut : adData[18:35]};
  end else if (incVma) begin
    next = vma + 23'd1;
  end else begin
    next = vma;
  end
  return next;
endfunction

// Flag bits in EBUS readout order
function automatic logic [0:3] modelFlags(
  input logic [13:35] vma,
  input logic [13:35] pc,
  input logic [13:35] adrBrk,
  input logic         vmaExtended,
  input logic         vmaFetch,
  input logic         pageUebrRef,
  input logic         vmaReadOrWrite
);
  logic sec01;
  logic loc;
  logic acRef;
  logic localAc;
  sec01 = (vma[13:17] == 5'd0) || (vma[13:17] == 5'd1);
  loc = ~vmaExtended | vmaFetch | sec01;
  acRef = loc & pageUebrRef & vmaReadOrWrite & (vma[18:31] == 14'b0);
  localAc = loc & ~sec01 & (vma[18:27] == 10'b0);
  return {acRef, localAc, adrBrk == vma, pc[13:17] == 5'b0};
endfunction

function automatic logic [0:35] modelEbus(
  input logic              readVma,
  input vmaPkg::diagSelT   diagSel,
  input logic [13:35]      vma,
  input logic [13:35]      held,
  input logic [13:35]      pc,
  input logic [13:35]      heldOrPc,
  input logic [13:35]      adrBrk,
  input logic [0:4]        prevSec,
  input logic [0:3]        flags
);
  logic [13:35] word;
  case (diagSel)
    vmaPkg::diagVma:      word = vma;
    vmaPkg::diagHeld:     word = held;
    vmaPkg::diagPc:       word = pc;
    vmaPkg::diagAdrBrk:   word = adrBrk;
    vmaPkg::diagPrevSec:  word = {prevSec, 17'b0, prevSec == 5'b0};
    vmaPkg::diagHeldOrPc: word = heldOrPc;
    vmaPkg::diagFlags:    word = {19'b0, flags};
    default:              word = '0;
  endcase
  return readVma ? {13'b0, word} : 36'b0;
endfunction

`endif

// ==== sim/vmaTb.sv ====
`timescale 1ns/10ps

module vmaTb import vmaPkg::*; ();

  localparam int clkPeriod = 4;
  localparam int resetCycles = 5;
  localparam int phaseCycles = 600;
  localparam int phaseCount = 5;
  localparam int totalCycles = resetCycles + 12 + phaseCount * phaseCycles;
  localparam int marginNs = 400;

  localparam int modeAdder = 0;
  localparam int modeCount = 1;
  localparam int modeContext = 2;
  localparam int modeAcRef = 3;
  localparam int modeDiag = 4;

  logic clk;
  logic reset;
  logic pcInc;
  logic [0:3] trapMix;
  logic condVmaMagic;
  logic [0:magicW-1] magic;
  logic [0:35] adData;
  logic loadVma;
  logic vmaFromAdder;
  secSrcT secSrc;
  logic incVma;
  logic loadPc;
  logic loadHeld;
  logic condSelVma;
  logic loadPrevContext;
  logic dataoApr;
  logic vmaExtended;
  logic vmaFetch;
  logic pageUebrRef;
  logic vmaReadOrWrite;
  logic readVma;
  diagSelT diagSel;
  vmaWordU vma;
  logic [13:35] pc;
  logic [13:35] held;
  logic [13:35] heldOrPc;
  logic [0:sectionW-1] prevSec;
  logic [13:35] adrBrk;
  logic pcsSection0;
  logic acRef;
  logic localAc;
  logic breakMatch;
  logic [0:35] ebusData;
  logic ebusDriving;

  // Model state
  logic [13:35] mVma;
  logic [13:35] mPc;
  logic [13:35] mHeld;
  logic [0:4] mPrevSec;
  logic [13:35] mAdrBrk;
  logic [0:17] mAdderOut;
  logic [13:35] mNextVma;
  logic [31:0] lfsrState;

  `include "vmaTbModel.svh"

  vmaTop u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(totalCycles * clkPeriod + marginNs);
    $display("Run timed out before all test phases finished");
    $display("Checks failed");
    $fatal(1);
  end

  always @(posedge clk) begin
    if (reset) begin
      mVma = '0;
      mPc = '0;
      mHeld = '0;
      mPrevSec = '0;
      mAdrBrk = '0;
    end else begin
      // Next VMA from the old PC, before PC itself moves
      mAdderOut = modelAdder(mPc, trapMix, pcInc, condVmaMagic, magic);
      mNextVma = modelNextVma(mVma, mPc, mPrevSec, adData, mAdderOut,
                              loadVma, incVma, vmaFromAdder, secSrc);
      if (loadPc) mPc = mVma;
      if (loadHeld) mHeld = mVma;
      if (loadPrevContext) mPrevSec = adData[13:17];
      if (dataoApr) mAdrBrk = adData[13:35];
      mVma = mNextVma;
    end
  end

  function automatic logic [31:0] stepLfsr(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  function automatic logic [35:0] randBits(input int n);
    logic [35:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = stepLfsr(lfsrState);
      value = {value[34:0], lfsrState[0]};
    end
    return value;
  endfunction

  // High with probability 1 in 2**bits
  function automatic logic chance(input int bits);
    return randBits(bits) == 36'd0;
  endfunction

  task automatic checkValue(input string testName, input string what,
                            input logic [35:0] expected, input logic [35:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s %s expected %h actual %h", testName, what, expected, actual);
      $display("Checks failed");
      $fatal(1);
    end
  endtask

  task automatic checkOutputs(input string testName);
    logic [0:3] flags;
    logic [13:35] expHeldOrPc;
    logic [0:35] expEbus;
    flags = modelFlags(mVma, mPc, mAdrBrk, vmaExtended, vmaFetch, pageUebrRef, vmaReadOrWrite);
    expHeldOrPc = condSelVma ? mHeld : mPc;
    expEbus = modelEbus(readVma, diagSel, mVma, mHeld, mPc, expHeldOrPc,
                        mAdrBrk, mPrevSec, flags);
    checkValue(testName, "vma", 36'(mVma), 36'(vma.flat));
    checkValue(testName, "pc", 36'(mPc), 36'(pc));
    checkValue(testName, "held", 36'(mHeld), 36'(held));
    checkValue(testName, "heldOrPc", 36'(expHeldOrPc), 36'(heldOrPc));
    checkValue(testName, "prevSec", 36'(mPrevSec), 36'(prevSec));
    checkValue(testName, "adrBrk", 36'(mAdrBrk), 36'(adrBrk));
    checkValue(testName, "pcsSection0", 36'(mPrevSec == 5'b0), 36'(pcsSection0));
    checkValue(testName, "acRef", 36'(flags[0]), 36'(acRef));
    checkValue(testName, "localAc", 36'(flags[1]), 36'(localAc));
    checkValue(testName, "breakMatch", 36'(flags[2]), 36'(breakMatch));
    checkValue(testName, "ebusData", 36'(expEbus), 36'(ebusData));
    checkValue(testName, "ebusDriving", 36'(readVma), 36'(ebusDriving));
  endtask

  task automatic clearInputs();
    {pcInc, condVmaMagic, loadVma, vmaFromAdder, incVma, loadPc, loadHeld} = '0;
    {condSelVma, loadPrevContext, dataoApr, readVma} = '0;
    {vmaExtended, vmaFetch, pageUebrRef, vmaReadOrWrite} = '0;
    trapMix = '0;
    magic = '0;
    adData = '0;
    secSrc = keepSec;
    diagSel = diagVma;
  endtask

  task automatic driveRandom(input int mode);
    pcInc = chance(1);
    trapMix = 4'(randBits(4));
    condVmaMagic = chance(2);
    magic = 9'(randBits(9));
    adData = randBits(36);
    loadVma = (mode == modeAdder || mode == modeAcRef) ? chance(1) : chance(2);
    vmaFromAdder = chance(1);
    secSrc = secSrcT'(2'(randBits(2)));
    incVma = (mode == modeCount) ? !chance(2) : chance(2);
    loadPc = (mode == modeDiag) ? chance(1) : chance(2);
    loadHeld = (mode == modeDiag) ? chance(1) : chance(2);
    condSelVma = chance(1);
    loadPrevContext = chance(2);
    dataoApr = chance(2);
    vmaExtended = chance(1);
    vmaFetch = chance(2);
    pageUebrRef = !chance(2);
    vmaReadOrWrite = !chance(2);
    readVma = (mode == modeDiag) ? 1'b1 : !chance(2);
    diagSel = diagSelT'(3'(randBits(3)));
    // Steer toward the corner cases of each phase
    if (mode == modeCount && chance(2)) begin
      adData[13:35] = '1;
      secSrc = adSec;
    end
    if (mode == modeContext) begin
      if (chance(1)) adData[13:35] = mVma;
      if (chance(2)) adData[13:17] = '0;
    end
    if (mode == modeAcRef) begin
      vmaFromAdder = 1'b0;
      if (chance(1)) adData[18:31] = '0;
      if (chance(1)) adData[13:16] = '0;
      if (chance(1)) diagSel = diagFlags;
    end
  endtask

  task automatic runPhase(input string testName, input int mode);
    repeat (phaseCycles) begin
      driveRandom(mode);
      @(negedge clk);
      checkOutputs(testName);
    end
  endtask

  initial begin
    lfsrState = 32'd18;
    clearInputs();
    reset = 1'b1;
    repeat (resetCycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    checkOutputs("reset");
    // Every readout word right after reset
    for (int sel = 0; sel < 8; sel++) begin
      readVma = 1'b1;
      diagSel = diagSelT'(3'(sel));
      @(negedge clk);
      checkOutputs("reset");
    end
    runPhase("adder", modeAdder);
    runPhase("count", modeCount);
    runPhase("context", modeContext);
    runPhase("acRef", modeAcRef);
    runPhase("diag", modeDiag);
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== source/vmaAddressPath.sv ====
`timescale 1ns/10ps

module vmaAddressPath import vmaPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pcInc,
  input  logic [0:3]            trapMix,
  input  logic                  condVmaMagic,
  input  logic [0:magicW-1]     magic,
  input  logic [0:35]           adData,
  input  logic                  loadVma,
  input  logic                  vmaFromAdder,
  input  secSrcT                secSrc,
  input  logic [0:sectionW-1]   prevSec,
  input  logic                  incVma,
  input  logic                  loadPc,
  input  logic                  loadHeld,
  input  logic                  condSelVma,
  output vmaWordU               vma,
  output logic [13:35]          pc,
  output logic [13:35]          held,
  output logic [13:35]          heldOrPc
);

  logic [0:inSectionW-1] adderOut;
  logic [0:inSectionW-1] inSecIn;
  logic [0:sectionW-1] secIn;

  // Address adder, or the magic constant in its place
  always_comb begin
    if (condVmaMagic) begin
      adderOut = {{(inSectionW - magicW){1'b0}}, magic};
    end else begin
      adderOut = pc[18:35]
               + {{(inSectionW - 4){1'b0}}, trapMix}
               + {{(inSectionW - 1){1'b0}}, pcInc};
    end
  end

  always_comb begin
    inSecIn = vmaFromAdder ? adderOut : adData[18:35];
  end

  // Section source mux
  always_comb begin
    case (secSrc)
      vmaPkg::keepSec: secIn = vma.field.section;
      vmaPkg::pcSec:   secIn = pc[13:17];
      vmaPkg::prevSec: secIn = prevSec;
      vmaPkg::adSec:   secIn = adData[13:17];
      default:         secIn = vma.field.section;
    endcase
  end

  // VMA register, load beats count
  always_ff @(posedge clk) begin
    if (reset) begin
      vma.flat <= '0;
    end else if (loadVma) begin
      vma.flat <= {secIn, inSecIn};
    end else if (incVma) begin
      vma.flat <= vma.flat + 23'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (loadPc) begin
      pc <= vma.flat;
    end
  end

  // Copy of VMA kept across a page fail
  always_ff @(posedge clk) begin
    if (reset) begin
      held <= '0;
    end else if (loadHeld) begin
      held <= vma.flat;
    end
  end

  always_comb begin
    heldOrPc = condSelVma ? held : pc;
  end

endmodule

// ==== source/vmaContextRegs.sv ====
`timescale 1ns/10ps

module vmaContextRegs import vmaPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [0:35]           adData,
  input  logic                  loadPrevContext,
  input  logic                  dataoApr,
  output logic [0:sectionW-1]   prevSec,
  output logic [13:35]          adrBrk,
  output logic                  pcsSection0
);

  // Previous context section for PXCT references
  always_ff @(posedge clk) begin
    if (reset) begin
      prevSec <= '0;
    end else if (loadPrevContext) begin
      prevSec <= adData[13:17];
    end
  end

  // Address break, written by DATAO APR
  always_ff @(posedge clk) begin
    if (reset) begin
      adrBrk <= '0;
    end else if (dataoApr) begin
      adrBrk <= adData[13:35];
    end
  end

  always_comb begin
    pcsSection0 = (prevSec == '0);
  end

endmodule

// ==== source/vmaPkg.sv ====
package vmaPkg;

  // Address field widths, big-endian numbering 13:35
  localparam int sectionW = 5;
  localparam int inSectionW = 18;
  localparam int magicW = 9;

  // Where the section field of a VMA load comes from
  typedef enum logic [1:0] {
    keepSec,
    pcSec,
    prevSec,
    adSec
  } secSrcT;

  // EBUS diagnostic readout selector
  typedef enum logic [2:0] {
    diagVma,
    diagHeld,
    diagPc,
    diagAdrBrk,
    diagPrevSec,
    diagHeldOrPc,
    diagFlags,
    diagNone
  } diagSelT;

  // Field view of a VMA word, bits 13:35
  typedef struct packed {
    logic [0:sectionW-1] section;
    logic [0:1] misc;
    logic [0:7] page;
    logic [0:3] block;
    logic [0:3] ac;
  } vmaFieldsT;

  typedef union packed {
    logic [13:35] flat;
    vmaFieldsT field;
  } vmaWordU;

endpackage

// ==== source/vmaStatus.sv ====
`timescale 1ns/10ps

module vmaStatus import vmaPkg::*; (
  input  vmaWordU               vma,
  input  logic [13:35]          pc,
  input  logic [13:35]          held,
  input  logic [13:35]          heldOrPc,
  input  logic [0:sectionW-1]   prevSec,
  input  logic [13:35]          adrBrk,
  input  logic                  pcsSection0,
  input  logic                  vmaExtended,
  input  logic                  vmaFetch,
  input  logic                  pageUebrRef,
  input  logic                  vmaReadOrWrite,
  input  logic                  readVma,
  input  diagSelT               diagSel,
  output logic                  acRef,
  output logic                  localAc,
  output logic                  breakMatch,
  output logic [0:35]           ebusData,
  output logic                  ebusDriving
);

  logic section01;
  logic isLocal;
  logic miscZero;
  logic pageZero;
  logic blockZero;
  logic pcSection0;
  logic [13:35] diagWord;

  // Section 0 or 1 differ only in the low bit
  always_comb begin
    section01 = (vma.field.section[0:sectionW-2] == '0);
    isLocal = ~vmaExtended | vmaFetch | section01;
    miscZero = (vma.field.misc == '0);
    pageZero = (vma.field.page == '0);
    blockZero = (vma.field.block == '0);
    pcSection0 = (pc[13:17] == '0);
  end

  // Fast memory reference
  always_comb begin
    acRef = isLocal & pageUebrRef & vmaReadOrWrite & miscZero & pageZero & blockZero;
    localAc = isLocal & ~section01 & miscZero & pageZero;
    breakMatch = (adrBrk == vma.flat);
  end

  // Diagnostic word, right-aligned on the EBUS
  always_comb begin
    case (diagSel)
      diagVma:      diagWord = vma.flat;
      diagHeld:     diagWord = held;
      diagPc:       diagWord = pc;
      diagAdrBrk:   diagWord = adrBrk;
      diagPrevSec:  diagWord = {prevSec, 17'b0, pcsSection0};
      diagHeldOrPc: diagWord = heldOrPc;
      diagFlags:    diagWord = {19'b0, acRef, localAc, breakMatch, pcSection0};
      default:      diagWord = '0;
    endcase
  end

  always_comb begin
    ebusData = readVma ? {13'b0, diagWord} : '0;
    ebusDriving = readVma;
  end

endmodule

// ==== source/vmaTop.sv ====
`timescale 1ns/10ps

module vmaTop import vmaPkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pcInc,
  input  logic [0:3]            trapMix,
  input  logic                  condVmaMagic,
  input  logic [0:magicW-1]     magic,
  input  logic [0:35]           adData,
  input  logic                  loadVma,
  input  logic                  vmaFromAdder,
  input  secSrcT                secSrc,
  input  logic                  incVma,
  input  logic                  loadPc,
  input  logic                  loadHeld,
  input  logic                  condSelVma,
  input  logic                  loadPrevContext,
  input  logic                  dataoApr,
  input  logic                  vmaExtended,
  input  logic                  vmaFetch,
  input  logic                  pageUebrRef,
  input  logic                  vmaReadOrWrite,
  input  logic                  readVma,
  input  diagSelT               diagSel,
  output vmaWordU               vma,
  output logic [13:35]          pc,
  output logic [13:35]          held,
  output logic [13:35]          heldOrPc,
  output logic [0:sectionW-1]   prevSec,
  output logic [13:35]          adrBrk,
  output logic                  pcsSection0,
  output logic                  acRef,
  output logic                  localAc,
  output logic                  breakMatch,
  output logic [0:35]           ebusData,
  output logic                  ebusDriving
);

  vmaAddressPath u_addressPath (
    .clk          (clk),
    .reset        (reset),
    .pcInc        (pcInc),
    .trapMix      (trapMix),
    .condVmaMagic (condVmaMagic),
    .magic        (magic),
    .adData       (adData),
    .loadVma      (loadVma),
    .vmaFromAdder (vmaFromAdder),
    .secSrc       (secSrc),
    .prevSec      (prevSec),
    .incVma       (incVma),
    .loadPc       (loadPc),
    .loadHeld     (loadHeld),
    .condSelVma   (condSelVma),
    .vma          (vma),
    .pc           (pc),
    .held         (held),
    .heldOrPc     (heldOrPc)
  );

  vmaContextRegs u_contextRegs (
    .clk             (clk),
    .reset           (reset),
    .adData          (adData),
    .loadPrevContext (loadPrevContext),
    .dataoApr        (dataoApr),
    .prevSec         (prevSec),
    .adrBrk          (adrBrk),
    .pcsSection0     (pcsSection0)
  );

  // Flags and readout see both register groups
  vmaStatus u_status (
    .vma            (vma),
    .pc             (pc),
    .held           (held),
    .heldOrPc       (heldOrPc),
    .prevSec        (prevSec),
    .adrBrk         (adrBrk),
    .pcsSection0    (pcsSection0),
    .vmaExtended    (vmaExtended),
    .vmaFetch       (vmaFetch),
    .pageUebrRef    (pageUebrRef),
    .vmaReadOrWrite (vmaReadOrWrite),
    .readVma        (readVma),
    .diagSel        (diagSel),
    .acRef          (acRef),
    .localAc        (localAc),
    .breakMatch     (breakMatch),
    .ebusData       (ebusData),
    .ebusDriving    (ebusDriving)
  );

endmodule
